// File: fetch_cases.txt
// freeze flush flush_pc dslot rfe ack err data | mask insn pc stall itlb immu ibus
// Mask bit 0 insn, bit 1 pc, bit 2 stall, bit 3 exceptions, a clear bit is not checked
0 0 00000000 0 0 0 0 00000000  f 14610000 00000100 1 0 0 0
0 0 00000000 0 0 1 0 9c600011  f 9c600011 00000100 0 0 0 0
0 0 00000000 0 0 1 0 9c800022  f 9c800022 00000104 0 0 0 0
0 0 00000000 0 0 1 0 9ca00033  f 9ca00033 00000108 0 0 0 0
0 0 00000000 0 0 1 0 9cc00044  f 9cc00044 0000010c 0 0 0 0
0 0 00000000 0 0 0 0 00000000  f 14610000 00000110 1 0 0 0
0 0 00000000 0 0 0 0 00000000  f 14610000 00000110 1 0 0 0
0 0 00000000 0 0 1 0 9ce00055  f 9ce00055 00000110 0 0 0 0
1 0 00000000 0 0 1 0 18208000  f 18208000 00000114 0 0 0 0
1 0 00000000 0 0 0 0 00000000  f 18208000 00000114 0 0 0 0
1 0 00000000 0 0 0 0 00000000  f 18208000 00000114 0 0 0 0
0 0 00000000 0 0 0 0 00000000  f 18208000 00000114 0 0 0 0
0 0 00000000 0 0 1 0 a8210004  f a8210004 00000118 0 0 0 0
0 1 00000400 0 0 1 0 9d000066  d 14410000 0000011c 0 0 0 0
0 0 00000000 0 0 1 0 9d200077  f 9d200077 00000400 0 0 0 0
0 0 00000000 0 1 1 0 9d400088  f 14410000 00000404 0 0 0 0
0 0 00000000 1 0 1 0 9d600099  f 14410000 00000408 0 0 0 0
0 1 00002040 0 0 1 0 9d8000aa  d 14410000 0000040c 0 0 0 0
0 0 00000000 0 0 1 0 9da000bb  f 14610000 00002040 0 0 1 0
0 0 00000000 1 0 1 0 9dc000cc  f 14410000 00002044 0 0 0 0
0 0 00000000 0 1 0 1 00000000  f 14410000 00002048 0 0 0 0
0 1 00008000 0 0 0 0 00000000  d 14410000 0000204c 1 0 0 0
0 0 00000000 0 0 1 0 9de000dd  f 14610000 00008000 0 1 0 0
0 0 00000000 0 0 0 1 00000000  f 14610000 00008004 0 1 0 0
0 1 00000500 0 0 0 0 00000000  d 14410000 00008008 1 0 0 0
0 0 00000000 0 0 0 1 00000000  f 14610000 00000500 0 0 0 1
0 0 00000000 0 0 1 0 9e0000ee  f 9e0000ee 00000504 0 0 0 0
1 0 00000000 0 0 0 1 00000000  f 14610000 00000508 0 0 0 1
1 0 00000000 0 0 0 0 00000000  f 14410000 00000508 0 0 0 1
0 0 00000000 0 0 0 0 00000000  f 14410000 00000508 0 0 0 1
0 0 00000000 0 0 1 0 9e2000ff  f 9e2000ff 0000050c 0 0 0 0
1 0 00000000 0 0 1 0 9e400101  f 9e400101 00000510 0 0 0 0
1 1 00000600 0 0 0 0 00000000  f 14410000 00000510 0 0 0 0
0 0 00000000 0 0 1 0 9e600202  f 9e600202 00000600 0 0 0 0

// File: sources.f
fetch_pkg.sv
pc_gen.sv
itag_gen.sv
insn_fetch.sv
fetch_top.sv
fetch_checker.sv
fetch_tb.sv

// File: Bender.yml
package:
  name: fetch_front

sources:
  - fetch_pkg.sv
  - pc_gen.sv
  - itag_gen.sv
  - insn_fetch.sv
  - fetch_top.sv
  - target: test
    files:
      - fetch_checker.sv
      - fetch_tb.sv

// File: fetch_tb.sv
//////////////////////////////////////////////////
// Fetch front end testbench
// Plays cases from a file cycle by cycle against
// the DUT, with the checker doing the compares
//////////////////////////////////////////////////

`default_nettype none
`timescale 1ns/10ps

module fetch_tb;

	// Fields per case line, see the file header
	localparam int case_fields = 15;
	localparam int max_cases   = 64;
	localparam int clk_period  = 20;
	localparam int drive_delay = 2;

	logic        clk;
	logic        rst_i;
	logic [31:0] icpu_dat_i;
	logic        icpu_ack_i;
	logic        icpu_err_i;
	logic [31:0] icpu_adr_o;
	logic        freeze_i;
	logic        flush_i;
	logic [31:0] flush_pc_i;
	logic        no_more_dslot_i;
	logic        rfe_i;
	logic [31:0] insn_o;
	logic [31:0] pc_o;
	logic        stall_o;
	logic        except_itlbmiss_o;
	logic        except_immufault_o;
	logic        except_ibuserr_o;

	// Expected side, handed to the checker
	logic        chk_en;
	logic [31:0] case_num;
	logic [3:0]  exp_mask;
	logic [31:0] exp_insn;
	logic [31:0] exp_pc;
	logic        exp_stall;
	logic        exp_itlb;
	logic        exp_immu;
	logic        exp_ibus;
	logic [31:0] error_count;
	logic [31:0] check_count;

	logic [31:0] case_mem [0:case_fields*max_cases-1];
	int          case_count = 0;

	fetch_top #(
		.reset_pc  (32'h0000_0100),
		.prot_base (32'h0000_2000),
		.prot_size (32'h0000_0100),
		.tlb_limit (32'h0000_8000)
	) fetch_top_i (
		.clk                (clk),
		.rst_i              (rst_i),
		.icpu_dat_i         (icpu_dat_i),
		.icpu_ack_i         (icpu_ack_i),
		.icpu_err_i         (icpu_err_i),
		.icpu_adr_o         (icpu_adr_o),
		.freeze_i           (freeze_i),
		.flush_i            (flush_i),
		.flush_pc_i         (flush_pc_i),
		.no_more_dslot_i    (no_more_dslot_i),
		.rfe_i              (rfe_i),
		.insn_o             (insn_o),
		.pc_o               (pc_o),
		.stall_o            (stall_o),
		.except_itlbmiss_o  (except_itlbmiss_o),
		.except_immufault_o (except_immufault_o),
		.except_ibuserr_o   (except_ibuserr_o)
	);

	fetch_checker checker_i (
		.clk           (clk),
		.chk_en_i      (chk_en),
		.case_num_i    (case_num),
		.mask_i        (exp_mask),
		.exp_insn_i    (exp_insn),
		.exp_pc_i      (exp_pc),
		.exp_stall_i   (exp_stall),
		.exp_itlb_i    (exp_itlb),
		.exp_immu_i    (exp_immu),
		.exp_ibus_i    (exp_ibus),
		.adr_i         (icpu_adr_o),
		.insn_i        (insn_o),
		.pc_i          (pc_o),
		.stall_i       (stall_o),
		.itlb_i        (except_itlbmiss_o),
		.immu_i        (except_immufault_o),
		.ibus_i        (except_ibuserr_o),
		.error_count_o (error_count),
		.check_count_o (check_count)
	);

	//////////////////////////////////////////////////
	// Case file handling
	//////////////////////////////////////////////////

	// Unfilled slots keep the all ones marker
	function automatic int count_cases();
		for (int n = 0; n < max_cases; n++) begin
			if (case_mem[n*case_fields] > 32'd1)
				return n;
		end
		return max_cases;
	endfunction

	// Stimulus and expected values of one line
	task apply_case(input int idx);
		int base;
		base = idx * case_fields;
		freeze_i        = case_mem[base][0];
		flush_i         = case_mem[base+1][0];
		flush_pc_i      = case_mem[base+2];
		no_more_dslot_i = case_mem[base+3][0];
		rfe_i           = case_mem[base+4][0];
		icpu_ack_i      = case_mem[base+5][0];
		icpu_err_i      = case_mem[base+6][0];
		icpu_dat_i      = case_mem[base+7];
		exp_mask        = case_mem[base+8][3:0];
		exp_insn        = case_mem[base+9];
		exp_pc          = case_mem[base+10];
		exp_stall       = case_mem[base+11][0];
		exp_itlb        = case_mem[base+12][0];
		exp_immu        = case_mem[base+13][0];
		exp_ibus        = case_mem[base+14][0];
		case_num        = idx;
		chk_en          = 1'b1;
	endtask

	//////////////////////////////////////////////////
	// Clock, stimulus and watchdog
	//////////////////////////////////////////////////

	initial begin
		clk = 1'b0;
		forever #(clk_period/2) clk = ~clk;
	end

	initial begin
		rst_i           = 1'b1;
		icpu_dat_i      = 32'h0;
		icpu_ack_i      = 1'b0;
		icpu_err_i      = 1'b0;
		freeze_i        = 1'b0;
		flush_i         = 1'b0;
		flush_pc_i      = 32'h0;
		no_more_dslot_i = 1'b0;
		rfe_i           = 1'b0;
		chk_en          = 1'b0;
		case_num        = 32'h0;
		exp_mask        = 4'h0;
		exp_insn        = 32'h0;
		exp_pc          = 32'h0;
		exp_stall       = 1'b0;
		exp_itlb        = 1'b0;
		exp_immu        = 1'b0;
		exp_ibus        = 1'b0;
		for (int n = 0; n < case_fields*max_cases; n++)
			case_mem[n] = 32'hffff_ffff;
		$readmemh("fetch_cases.txt", case_mem);
		case_count = count_cases();
		if (case_count == 0) begin
			$display("no test cases could be read from fetch_cases.txt");
		end else begin
			// Reset over three edges, released with the first case
			repeat (3) @(posedge clk);
			#drive_delay;
			rst_i = 1'b0;
			for (int i = 0; i < case_count; i++) begin
				apply_case(i);
				@(posedge clk);
				#drive_delay;
			end
			chk_en = 1'b0;
		end
		$display("cases run: %0d, checks: %0d, errors: %0d",
			case_count, check_count, error_count);
		if (case_count > 0 && check_count > 0 && error_count == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

	// Run length plus margin for reset and the last edge
	initial begin
		wait (case_count > 0);
		#(case_count * clk_period + 200);
		$display("the run timed out before all cases were played");
		$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// File: fetch_checker.sv
//////////////////////////////////////////////////
// Fetch front end output monitor
// Compares DUT outputs with the expected values
// of the current case and counts the mismatches
//////////////////////////////////////////////////

`default_nettype none
`timescale 1ns/10ps

module fetch_checker (
	input  wire        clk,
	// Expected values from the case file
	input  wire        chk_en_i,
	input  wire [31:0] case_num_i,
	input  wire [3:0]  mask_i,
	input  wire [31:0] exp_insn_i,
	input  wire [31:0] exp_pc_i,
	input  wire        exp_stall_i,
	input  wire        exp_itlb_i,
	input  wire        exp_immu_i,
	input  wire        exp_ibus_i,
	// Observed DUT outputs
	input  wire [31:0] adr_i,
	input  wire [31:0] insn_i,
	input  wire [31:0] pc_i,
	input  wire        stall_i,
	input  wire        itlb_i,
	input  wire        immu_i,
	input  wire        ibus_i,
	output logic [31:0] error_count_o,
	output logic [31:0] check_count_o
);

	// 2 ns before the next rising edge
	localparam int sample_delay = 18;

	int errors = 0;
	int checks = 0;

	assign error_count_o = errors;
	assign check_count_o = checks;

	// One field, one compare, X counts as wrong
	task compare_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		checks = checks + 1;
		if (actual !== expected) begin
			errors = errors + 1;
			$display("error %s case %0d: expected %h, actual %h",
				name, case_num_i, expected, actual);
		end
	endtask

	//////////////////////////////////////////////////
	// Sampling
	//////////////////////////////////////////////////

	// Outputs settled well after the 2 ns drive point
	always begin
		@(posedge clk);
		#sample_delay;
		if (chk_en_i) begin
			if (mask_i[0])
				compare_value("insn_o", exp_insn_i, insn_i);
			if (mask_i[1]) begin
				compare_value("pc_o", exp_pc_i, pc_i);
				// Address on the port belongs to the word shown
				compare_value("icpu_adr_o", exp_pc_i, adr_i);
			end
			if (mask_i[2])
				compare_value("stall_o", {31'b0, exp_stall_i}, {31'b0, stall_i});
			// Exceptions as one group
			if (mask_i[3]) begin
				compare_value("except_itlbmiss_o", {31'b0, exp_itlb_i}, {31'b0, itlb_i});
				compare_value("except_immufault_o", {31'b0, exp_immu_i}, {31'b0, immu_i});
				compare_value("except_ibuserr_o", {31'b0, exp_ibus_i}, {31'b0, ibus_i});
			end
		end
	end

endmodule

`default_nettype wire

// File: fetch_top.sv
//////////////////////////////////////////////////
// Fetch front end top level
// PC generator, address checker and fetch stage
//////////////////////////////////////////////////

`default_nettype none
`timescale 1ns/10ps

module fetch_top #(
	parameter logic [fetch_pkg::insn_width-1:0] reset_pc  = 32'h0000_0100,
	parameter logic [fetch_pkg::insn_width-1:0] prot_base = 32'h0000_2000,
	parameter logic [fetch_pkg::insn_width-1:0] prot_size = 32'h0000_0100,
	parameter logic [fetch_pkg::insn_width-1:0] tlb_limit = 32'h0000_8000
) (
	input  wire                              clk,
	input  wire                              rst_i,
	// Instruction port, cache side
	input  wire [fetch_pkg::insn_width-1:0]  icpu_dat_i,
	input  wire                              icpu_ack_i,
	input  wire                              icpu_err_i,
	output logic [fetch_pkg::insn_width-1:0] icpu_adr_o,
	// Pipeline control
	input  wire                              freeze_i,
	input  wire                              flush_i,
	input  wire [fetch_pkg::insn_width-1:0]  flush_pc_i,
	input  wire                              no_more_dslot_i,
	input  wire                              rfe_i,
	// Towards decode
	output logic [fetch_pkg::insn_width-1:0] insn_o,
	output logic [fetch_pkg::insn_width-1:0] pc_o,
	output logic                             stall_o,
	output logic                             except_itlbmiss_o,
	output logic                             except_immufault_o,
	output logic                             except_ibuserr_o
);

	logic [fetch_pkg::insn_width-1:0] fetch_adr;
	logic                             chk_ack;
	logic                             chk_err;
	logic [3:0]                       chk_tag;
	logic                             genpc_refetch;

	assign icpu_adr_o = fetch_adr;

	pc_gen #(
		.reset_pc   (reset_pc)
	) pc_gen_i (
		.clk        (clk),
		.rst_i      (rst_i),
		.flush_i    (flush_i),
		.flush_pc_i (flush_pc_i),
		.freeze_i   (freeze_i),
		.stall_i    (stall_o),
		.refetch_i  (genpc_refetch),
		.pc_o       (fetch_adr)
	);

	itag_gen #(
		.prot_base (prot_base),
		.prot_size (prot_size),
		.tlb_limit (tlb_limit)
	) itag_gen_i (
		.adr_i     (fetch_adr),
		.ack_i     (icpu_ack_i),
		.err_i     (icpu_err_i),
		.ack_o     (chk_ack),
		.err_o     (chk_err),
		.tag_o     (chk_tag)
	);

	// Save strobe has no consumer without an SPR block
	insn_fetch insn_fetch_i (
		.clk                (clk),
		.rst_i              (rst_i),
		.icpu_dat_i         (icpu_dat_i),
		.icpu_ack_i         (chk_ack),
		.icpu_err_i         (chk_err),
		.icpu_adr_i         (fetch_adr),
		.icpu_tag_i         (chk_tag),
		.if_freeze_i        (freeze_i),
		.if_flushpipe_i     (flush_i),
		.no_more_dslot_i    (no_more_dslot_i),
		.rfe_i              (rfe_i),
		.if_insn_o          (insn_o),
		.if_pc_o            (pc_o),
		.saving_if_insn_o   (),
		.if_stall_o         (stall_o),
		.genpc_refetch_o    (genpc_refetch),
		.except_itlbmiss_o  (except_itlbmiss_o),
		.except_immufault_o (except_immufault_o),
		.except_ibuserr_o   (except_ibuserr_o)
	);

endmodule

`default_nettype wire

// File: insn_fetch.sv
//////////////////////////////////////////////////
// Instruction fetch stage
// Presents word and PC to decode, saves a response
// that lands during freeze, inserts NOPs on flush
// and raises the three fetch exceptions
//////////////////////////////////////////////////

`default_nettype none
`timescale 1ns/10ps

module insn_fetch (
	input  wire                              clk,
	input  wire                              rst_i,
	// Cache side, already checked
	input  wire [fetch_pkg::insn_width-1:0]  icpu_dat_i,
	input  wire                              icpu_ack_i,
	input  wire                              icpu_err_i,
	input  wire [fetch_pkg::insn_width-1:0]  icpu_adr_i,
	input  wire [3:0]                        icpu_tag_i,
	// Pipeline control
	input  wire                              if_freeze_i,
	input  wire                              if_flushpipe_i,
	input  wire                              no_more_dslot_i,
	input  wire                              rfe_i,
	// Towards decode and the PC generator
	output logic [fetch_pkg::insn_width-1:0] if_insn_o,
	output logic [fetch_pkg::insn_width-1:0] if_pc_o,
	output logic                             saving_if_insn_o,
	output logic                             if_stall_o,
	output logic                             genpc_refetch_o,
	output logic                             except_itlbmiss_o,
	output logic                             except_immufault_o,
	output logic                             except_ibuserr_o
);

	logic                             save_insn;
	logic                             saved;
	logic [fetch_pkg::insn_width-1:0] insn_saved;
	logic [fetch_pkg::insn_width-1:0] addr_saved;
	// Bit 0 TLB miss, bit 1 protection, bit 2 bus error
	logic [2:0]                       err_saved;
	logic [2:0]                       err_live;
	logic [fetch_pkg::insn_width-1:0] adr_last;
	logic                             new_adr;
	logic                             if_bypass;
	logic                             if_bypass_reg;
	logic                             kill_slot;
	logic                             kill_exc;

	// Any response while frozen and nothing held yet
	assign save_insn = (icpu_ack_i | icpu_err_i) & if_freeze_i & ~saved;
	assign saving_if_insn_o = ~if_flushpipe_i & save_insn;

	// Decode the tag of the live response
	assign err_live[0] = icpu_err_i & (icpu_tag_i == fetch_pkg::itag_te);
	assign err_live[1] = icpu_err_i & (icpu_tag_i == fetch_pkg::itag_pe);
	assign err_live[2] = icpu_err_i & (icpu_tag_i == fetch_pkg::itag_be);

	//////////////////////////////////////////////////
	// Flush bypass
	//////////////////////////////////////////////////

	// Last address seen, to spot the redirect landing
	always_ff @(posedge clk) begin
		adr_last <= icpu_adr_i;
	end

	assign new_adr = icpu_adr_i != adr_last;

	// NOP out until the fetch address moves
	assign if_bypass = if_flushpipe_i | (if_bypass_reg & ~new_adr);

	always_ff @(posedge clk) begin
		if (rst_i) begin
			if_bypass_reg <= 1'b0;
		end else begin
			if_bypass_reg <= if_bypass;
		end
	end

	//////////////////////////////////////////////////
	// Saved response
	//////////////////////////////////////////////////

	// Flush wins, then save, then drop once unfrozen
	always_ff @(posedge clk) begin
		if (rst_i) begin
			saved <= 1'b0;
		end else if (if_flushpipe_i) begin
			saved <= 1'b0;
		end else if (save_insn) begin
			saved <= 1'b1;
		end else if (!if_freeze_i) begin
			saved <= 1'b0;
		end
	end

	// Word, address and error bits of the held response
	always_ff @(posedge clk) begin
		if (saving_if_insn_o) begin
			// Errored fetch holds a NOP, not garbage data
			insn_saved <= icpu_err_i ? fetch_pkg::nop_flush : icpu_dat_i;
			addr_saved <= {icpu_adr_i[fetch_pkg::insn_width-1:2], 2'b00};
			err_saved  <= err_live;
		end
	end

	//////////////////////////////////////////////////
	// Outputs to decode
	//////////////////////////////////////////////////

	assign kill_slot = no_more_dslot_i | rfe_i | if_bypass;
	assign kill_exc  = no_more_dslot_i | rfe_i;

	// Killed slot, held word, live word, else bubble
	always_comb begin
		if (kill_slot) begin
			if_insn_o = fetch_pkg::nop_flush;
		end else if (saved) begin
			if_insn_o = insn_saved;
		end else if (icpu_ack_i) begin
			if_insn_o = icpu_dat_i;
		end else begin
			if_insn_o = fetch_pkg::nop_idle;
		end
	end

	assign if_pc_o = saved ? addr_saved : {icpu_adr_i[fetch_pkg::insn_width-1:2], 2'b00};

	// Nothing to show this cycle
	assign if_stall_o = ~icpu_err_i & ~icpu_ack_i & ~saved;

	// New ack behind a held word, PC must stay put
	assign genpc_refetch_o = saved & icpu_ack_i;

	// Held error bits take over while a word is saved
	assign except_itlbmiss_o  = kill_exc ? 1'b0 : (saved ? err_saved[0] : err_live[0]);
	assign except_immufault_o = kill_exc ? 1'b0 : (saved ? err_saved[1] : err_live[1]);
	assign except_ibuserr_o   = kill_exc ? 1'b0 : (saved ? err_saved[2] : err_live[2]);

	//////////////////////////////////////////////////
	// Checks
	//////////////////////////////////////////////////

	// Closed delay slot never traps, saved or live
	dslot_no_exc_a: assert property (
		@(posedge clk) disable iff (rst_i)
		no_more_dslot_i |-> !(except_itlbmiss_o || except_immufault_o || except_ibuserr_o)
	) else $error("fetch exception raised with delay slot closed");

	// A save shows up as a held word next cycle
	save_sets_flag_a: assert property (
		@(posedge clk) disable iff (rst_i)
		saving_if_insn_o |=> saved
	) else $error("saved flag missing after save");

	// Flush drops any held word
	flush_clears_a: assert property (
		@(posedge clk) disable iff (rst_i)
		if_flushpipe_i |=> !saved
	) else $error("saved word survived a flush");

endmodule

`default_nettype wire

// File: itag_gen.sv
//////////////////////////////////////////////////
// Fetch address checker
// Range and protection checks in front of the
// cache response, merged with bus err into a tag
//////////////////////////////////////////////////

`default_nettype none
`timescale 1ns/10ps

module itag_gen #(
	parameter logic [fetch_pkg::insn_width-1:0] prot_base = 32'h0000_2000,
	parameter logic [fetch_pkg::insn_width-1:0] prot_size = 32'h0000_0100,
	parameter logic [fetch_pkg::insn_width-1:0] tlb_limit = 32'h0000_8000
) (
	input  wire [fetch_pkg::insn_width-1:0] adr_i,
	// Raw response from the cache side
	input  wire                             ack_i,
	input  wire                             err_i,
	// Checked response towards fetch
	output logic                            ack_o,
	output logic                            err_o,
	output logic [3:0]                      tag_o
);

	// One bit wider so a window at the top of memory
	// does not wrap
	localparam logic [fetch_pkg::insn_width:0] prot_end =
		{1'b0, prot_base} + {1'b0, prot_size};

	logic te_hit;
	logic pe_hit;
	logic chk_fail;

	//////////////////////////////////////////////////
	// Address checks
	//////////////////////////////////////////////////

	// Nothing mapped at or above the limit
	assign te_hit = adr_i >= tlb_limit;

	// Protected window, base inclusive, end exclusive
	assign pe_hit = (adr_i >= prot_base) && ({1'b0, adr_i} < prot_end);

	assign chk_fail = te_hit | pe_hit;

	//////////////////////////////////////////////////
	// Response merge
	//////////////////////////////////////////////////

	// Bus ack passes only if the address checks pass
	assign ack_o = ack_i & ~chk_fail;

	// Failed check turns an ack into an error
	assign err_o = err_i | (ack_i & chk_fail);

	// Tag priority: TLB miss, protection, bus error
	always_comb begin
		tag_o = fetch_pkg::itag_none;
		if (err_o) begin
			if (te_hit) begin
				tag_o = fetch_pkg::itag_te;
			end else if (pe_hit) begin
				tag_o = fetch_pkg::itag_pe;
			end else begin
				tag_o = fetch_pkg::itag_be;
			end
		end
	end

	// Fetch stage treats ack and err as exclusive
	ack_err_excl_a: assert final (!(ack_o && err_o))
		else $error("ack and err both high at %h", adr_i);

endmodule

`default_nettype wire

// File: pc_gen.sv
//////////////////////////////////////////////////
// Program counter generator
// Holds the fetch address, redirects on flush,
// holds on stall, freeze or refetch, else steps 4
//////////////////////////////////////////////////

`default_nettype none
`timescale 1ns/10ps

module pc_gen #(
	parameter logic [fetch_pkg::insn_width-1:0] reset_pc = 32'h0000_0100
) (
	input  wire                                clk,
	input  wire                                rst_i,
	// Redirect from the pipeline
	input  wire                                flush_i,
	input  wire [fetch_pkg::insn_width-1:0]    flush_pc_i,
	// Hold conditions
	input  wire                                freeze_i,
	input  wire                                stall_i,
	input  wire                                refetch_i,
	output logic [fetch_pkg::insn_width-1:0]   pc_o
);

	// Word aligned copy of the redirect target
	logic [fetch_pkg::insn_width-1:0] pc_flush_aligned;
	logic [fetch_pkg::insn_width-1:0] pc_next_seq;
	logic                             pc_hold;

	assign pc_flush_aligned = {flush_pc_i[fetch_pkg::insn_width-1:2], 2'b00};

	// Sequential advance, one word
	assign pc_next_seq = pc_o + 32'd4;

	// No response yet, pipeline frozen, or saved word
	// collides with a fresh ack and must be re-presented
	assign pc_hold = stall_i | freeze_i | refetch_i;

	//////////////////////////////////////////////////
	// PC register
	//////////////////////////////////////////////////

	// Priority is reset, redirect, hold, advance
	always_ff @(posedge clk) begin
		if (rst_i) begin
			pc_o <= reset_pc;
		end else if (flush_i) begin
			pc_o <= pc_flush_aligned;
		end else if (!pc_hold) begin
			pc_o <= pc_next_seq;
		end
	end

	//////////////////////////////////////////////////
	// Checks
	//////////////////////////////////////////////////

	// Cache side only takes whole words
	pc_aligned_a: assert property (
		@(posedge clk) disable iff (rst_i)
		pc_o[1:0] == 2'b00
	) else $error("fetch PC %h not word aligned", pc_o);

endmodule

`default_nettype wire

// File: fetch_pkg.sv
//////////////////////////////////////////////////
// Instruction fetch shared definitions
// Word width, NOP encodings and the error tags
// that the address checker hands to the fetch stage
//////////////////////////////////////////////////

`default_nettype none

package fetch_pkg;

	//////////////////////////////////////////////////
	// Word width
	//////////////////////////////////////////////////

	// Instruction and address width
	localparam int unsigned insn_width = 32;

	//////////////////////////////////////////////////
	// NOP encodings
	//////////////////////////////////////////////////

	// Major opcode of l.nop
	localparam logic [5:0] nop_opcode = 6'h05;

	// Slot killed by flush, rfe or closed delay slot
	localparam logic [insn_width-1:0] nop_flush = {nop_opcode, 26'h041_0000};

	// Nothing fetched yet, pipeline sees a bubble
	localparam logic [insn_width-1:0] nop_idle = {nop_opcode, 26'h061_0000};

	//////////////////////////////////////////////////
	// Fetch error tags
	//////////////////////////////////////////////////

	localparam logic [3:0] itag_none = 4'h0;
	// Bus error from the cache side
	localparam logic [3:0] itag_be = 4'hb;
	// Protection fault
	localparam logic [3:0] itag_pe = 4'hc;
	// TLB miss
	localparam logic [3:0] itag_te = 4'hd;

endpackage

`default_nettype wire
